// File: include/noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Flit geometry
`define NOC_LANES 4
`define NOC_LANEW 8
`define NOC_DATAW 32

// Network size and sideband widths
`define NOC_NODES 4   // Leaf PEs on the hub
`define NOC_DESTW 3   // Host is node 0, PEs are 1 to 4
`define NOC_TAGW  6

`endif

// File: verilog/noc_pkg.sv
`include "noc_config.svh"

package noc_pkg;

    // Node ids on the star
    typedef logic [`NOC_DESTW-1:0] node_id_t;

    // Index of a hub port, 0 is PE 1
    typedef logic [$clog2(`NOC_NODES)-1:0] port_idx_t;

    // One signed lane word
    typedef logic signed [`NOC_LANEW-1:0] lane_t;

    // Lane 0 sits in the low bits
    typedef logic [`NOC_DATAW-1:0] flit_data_t;

    typedef logic [$clog2(`NOC_LANES)-1:0] lane_idx_t;

    // Request tag, returned with the result
    typedef logic [`NOC_TAGW-1:0] tag_t;

endpackage

// File: verilog/pe_pkg.sv
package pe_pkg;

    // Lane-wise operation carried with each flit
    typedef enum logic [1:0] {
        OP_PASS   = 2'd0,
        OP_RELU   = 2'd1,
        OP_SUM    = 2'd2,  // Wrapped sum into lane 0
        OP_DOUBLE = 2'd3
    } pe_op_e;

    // PE control states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_SEND = 2'd2
    } pe_state_e;

endpackage

// File: verilog/lane_counter.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module lane_counter
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    output lane_idx_t lane_idx,
    output logic      busy,
    output logic      last
);

    assign last = busy && (lane_idx == lane_idx_t'(`NOC_LANES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            lane_idx <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            lane_idx <= '0;
        end else if (busy) begin
            busy     <= !last;   // Stops after the final lane
            lane_idx <= lane_idx + 1'b1;
        end
    end

endmodule

// File: verilog/pe_lanes.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module pe_lanes
    import noc_pkg::*;
    import pe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  flit_data_t data,
    input  pe_op_e     op,
    input  lane_idx_t  lane_idx,
    input  logic       step,
    output flit_data_t result
);

    flit_data_t opnd;
    flit_data_t res;
    lane_t      acc;
    lane_t      cur_lane;
    lane_t      proc_lane;
    lane_t      sum_next;

    assign result = res;

    // Lane selected by the counter
    always_comb begin
        cur_lane = lane_t'(opnd[lane_idx*`NOC_LANEW +: `NOC_LANEW]);
        sum_next = acc + cur_lane;   // Wraps at 8 bits
        case (op)
            OP_PASS:   proc_lane = cur_lane;
            OP_RELU:   proc_lane = cur_lane[`NOC_LANEW-1] ? '0 : cur_lane;
            OP_SUM:    proc_lane = '0;
            OP_DOUBLE: proc_lane = cur_lane << 1;
            default:   proc_lane = cur_lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (load) begin
            acc <= '0;
        end else if (step && op == OP_SUM) begin
            acc <= sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opnd <= data;
        end else if (step) begin
            res[lane_idx*`NOC_LANEW +: `NOC_LANEW] <= proc_lane;
            if (op == OP_SUM) begin
                res[`NOC_LANEW-1:0] <= sum_next;   // Running sum lives in lane 0
            end
        end
    end

endmodule

// File: verilog/pe_ctrl.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module pe_ctrl
    import noc_pkg::*;
    import pe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  flit_data_t in_tdata,
    input  pe_op_e     in_top,
    input  tag_t       in_ttag,
    output logic       out_tvalid,
    input  logic       out_tready,
    output flit_data_t out_tdata,
    output pe_op_e     out_top,
    output tag_t       out_ttag
);

    pe_state_e state;
    pe_op_e    op_q;
    tag_t      tag_q;
    lane_idx_t lane_idx;
    logic      accept;
    logic      busy;
    logic      last;

    assign in_tready  = (state == ST_IDLE);
    assign accept     = in_tvalid && in_tready;
    assign out_tvalid = (state == ST_SEND);
    assign out_top    = op_q;
    assign out_ttag   = tag_q;

    // -------------------------------------------------------------------------
    // Control FSM
    // -------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) state <= ST_RUN;
                end
                ST_RUN: begin
                    if (last) state <= ST_SEND;   // One lane per cycle
                end
                ST_SEND: begin
                    if (out_tready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Sideband held until the hub takes the result
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= in_top;
            tag_q <= in_ttag;
        end
    end

    lane_counter u_cnt (
        .clk      (clk),
        .rst      (rst),
        .start    (accept),
        .lane_idx (lane_idx),
        .busy     (busy),
        .last     (last)
    );

    pe_lanes u_lanes (
        .clk      (clk),
        .rst      (rst),
        .load     (accept),
        .data     (in_tdata),
        .op       (op_q),
        .lane_idx (lane_idx),
        .step     (busy),
        .result   (out_tdata)
    );

endmodule

// File: verilog/hub_router.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module hub_router
    import noc_pkg::*;
    import pe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  flit_data_t            s_tdata,
    input  node_id_t              s_tdest,
    input  pe_op_e                s_top,
    input  tag_t                  s_ttag,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output flit_data_t            m_tdata,
    output node_id_t              m_tdest,
    output pe_op_e                m_top,
    output tag_t                  m_ttag,
    output logic [`NOC_NODES-1:0] pe_in_tvalid,
    input  logic [`NOC_NODES-1:0] pe_in_tready,
    output flit_data_t            pe_in_tdata [`NOC_NODES],
    output pe_op_e                pe_in_top [`NOC_NODES],
    output tag_t                  pe_in_ttag [`NOC_NODES],
    input  logic [`NOC_NODES-1:0] pe_out_tvalid,
    output logic [`NOC_NODES-1:0] pe_out_tready,
    input  flit_data_t            pe_out_tdata [`NOC_NODES],
    input  pe_op_e                pe_out_top [`NOC_NODES],
    input  tag_t                  pe_out_ttag [`NOC_NODES]
);

    logic       in_full;
    flit_data_t in_data;
    node_id_t   in_dest;
    pe_op_e     in_op;
    tag_t       in_tag;
    logic       dest_ok;
    logic       routed;
    port_idx_t  rr_ptr;
    port_idx_t  gnt_idx;
    logic       gnt_any;
    logic       slot_free;

    // -------------------------------------------------------------------------
    // Request side
    // -------------------------------------------------------------------------
    assign s_tready = !in_full;
    assign dest_ok  = (in_dest != '0) && (in_dest <= node_id_t'(`NOC_NODES));
    assign routed   = |(pe_in_tvalid & pe_in_tready);

    // Payload fans out to every PE, only the target sees valid
    always_comb begin
        for (int i = 0; i < `NOC_NODES; i++) begin
            pe_in_tvalid[i] = in_full && (in_dest == node_id_t'(i + 1));
            pe_in_tdata[i]  = in_data;
            pe_in_top[i]    = in_op;
            pe_in_ttag[i]   = in_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_full <= 1'b0;
        end else if (s_tvalid && s_tready) begin
            in_full <= 1'b1;
        end else if (routed || (in_full && !dest_ok)) begin
            in_full <= 1'b0;   // Delivered or dropped
        end
    end

    always_ff @(posedge clk) begin
        if (s_tvalid && s_tready) begin
            in_data <= s_tdata;
            in_dest <= s_tdest;
            in_op   <= s_top;
            in_tag  <= s_ttag;
        end
    end

    // -------------------------------------------------------------------------
    // Return side, round robin over the PEs
    // -------------------------------------------------------------------------
    assign slot_free = !m_tvalid || m_tready;

    always_comb begin
        port_idx_t idx;
        gnt_any = 1'b0;
        gnt_idx = rr_ptr;
        for (int k = 0; k < `NOC_NODES; k++) begin
            idx = rr_ptr + port_idx_t'(k);   // Wraps around the ring
            if (!gnt_any && pe_out_tvalid[idx]) begin
                gnt_any = 1'b1;
                gnt_idx = idx;
            end
        end
        pe_out_tready          = '0;
        pe_out_tready[gnt_idx] = slot_free && gnt_any;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid <= 1'b0;
            rr_ptr   <= '0;   // PE 1 first
        end else if (slot_free) begin
            m_tvalid <= gnt_any;
            if (gnt_any) begin
                rr_ptr <= gnt_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_free && gnt_any) begin
            m_tdata <= pe_out_tdata[gnt_idx];
            m_tdest <= node_id_t'(gnt_idx) + node_id_t'(1);   // Source PE id
            m_top   <= pe_out_top[gnt_idx];
            m_ttag  <= pe_out_ttag[gnt_idx];
        end
    end

endmodule

// File: verilog/noc_star_top.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module noc_star_top
    import noc_pkg::*;
    import pe_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s_tvalid,
    output logic       s_tready,
    input  flit_data_t s_tdata,
    input  node_id_t   s_tdest,
    input  pe_op_e     s_top,
    input  tag_t       s_ttag,
    output logic       m_tvalid,
    input  logic       m_tready,
    output flit_data_t m_tdata,
    output node_id_t   m_tdest,
    output pe_op_e     m_top,
    output tag_t       m_ttag
);

    // Hub to PE links
    logic [`NOC_NODES-1:0] pe_in_tvalid;
    logic [`NOC_NODES-1:0] pe_in_tready;
    flit_data_t            pe_in_tdata [`NOC_NODES];
    pe_op_e                pe_in_top [`NOC_NODES];
    tag_t                  pe_in_ttag [`NOC_NODES];

    // PE to hub links
    logic [`NOC_NODES-1:0] pe_out_tvalid;
    logic [`NOC_NODES-1:0] pe_out_tready;
    flit_data_t            pe_out_tdata [`NOC_NODES];
    pe_op_e                pe_out_top [`NOC_NODES];
    tag_t                  pe_out_ttag [`NOC_NODES];

    hub_router u_hub (
        .clk           (clk),
        .rst           (rst),
        .s_tvalid      (s_tvalid),
        .s_tready      (s_tready),
        .s_tdata       (s_tdata),
        .s_tdest       (s_tdest),
        .s_top         (s_top),
        .s_ttag        (s_ttag),
        .m_tvalid      (m_tvalid),
        .m_tready      (m_tready),
        .m_tdata       (m_tdata),
        .m_tdest       (m_tdest),
        .m_top         (m_top),
        .m_ttag        (m_ttag),
        .pe_in_tvalid  (pe_in_tvalid),
        .pe_in_tready  (pe_in_tready),
        .pe_in_tdata   (pe_in_tdata),
        .pe_in_top     (pe_in_top),
        .pe_in_ttag    (pe_in_ttag),
        .pe_out_tvalid (pe_out_tvalid),
        .pe_out_tready (pe_out_tready),
        .pe_out_tdata  (pe_out_tdata),
        .pe_out_top    (pe_out_top),
        .pe_out_ttag   (pe_out_ttag)
    );

    // Index i serves node id i+1
    for (genvar i = 0; i < `NOC_NODES; i++) begin : g_pe
        pe_ctrl u_pe (
            .clk        (clk),
            .rst        (rst),
            .in_tvalid  (pe_in_tvalid[i]),
            .in_tready  (pe_in_tready[i]),
            .in_tdata   (pe_in_tdata[i]),
            .in_top     (pe_in_top[i]),
            .in_ttag    (pe_in_ttag[i]),
            .out_tvalid (pe_out_tvalid[i]),
            .out_tready (pe_out_tready[i]),
            .out_tdata  (pe_out_tdata[i]),
            .out_top    (pe_out_top[i]),
            .out_ttag   (pe_out_ttag[i])
        );
    end

endmodule

// File: bench/tb_noc_star.sv
`timescale 1ns/1ns
`include "noc_config.svh"

module tb_noc_star
    import noc_pkg::*;
    import pe_pkg::*;
();

    localparam int NUM_FLITS  = 200;
    localparam int RST_CYCLES = 10;
    localparam int MAX_CYCLES = NUM_FLITS * 40 + RST_CYCLES;
    localparam int NUM_TAGS   = 1 << `NOC_TAGW;
    localparam int T_RESET    = 0;
    localparam int T_ROUTE    = 1;
    localparam int T_DATA     = 2;
    localparam int T_DONE     = 3;
    localparam int T_HOLD     = 4;

    logic       clk;
    logic       rst;
    logic       s_tvalid;
    logic       s_tready;
    flit_data_t s_tdata;
    node_id_t   s_tdest;
    pe_op_e     s_top;
    tag_t       s_ttag;
    logic       m_tvalid;
    logic       m_tready;
    flit_data_t m_tdata;
    node_id_t   m_tdest;
    pe_op_e     m_top;
    tag_t       m_ttag;

    // Scoreboard indexed by tag
    flit_data_t  exp_data [NUM_TAGS];
    node_id_t    exp_dest [NUM_TAGS];
    pe_op_e      exp_op [NUM_TAGS];
    logic        pending [NUM_TAGS];
    int          errors [5];
    string       test_name [5] = '{"reset", "routing", "data", "completion", "hold"};
    logic [31:0] rng_state;
    int          sent;
    int          outstanding;
    int          cycles;
    logic        timed_out;
    logic        held;     // Output stalled on the last sample
    flit_data_t  hold_data;
    node_id_t    hold_dest;
    pe_op_e      hold_op;
    tag_t        hold_tag;

    noc_star_top UUT (.*);

    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // Random source and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic flit_data_t model_result(input flit_data_t d, input pe_op_e op);
        flit_data_t r;
        lane_t      l;
        lane_t      sum;
        r   = '0;
        sum = '0;
        for (int i = 0; i < `NOC_LANES; i++) begin
            l = lane_t'(d[i*`NOC_LANEW +: `NOC_LANEW]);
            case (op)
                OP_PASS:   r[i*`NOC_LANEW +: `NOC_LANEW] = l;
                OP_RELU:   r[i*`NOC_LANEW +: `NOC_LANEW] = (l < 0) ? lane_t'(0) : l;
                OP_SUM:    sum = sum + l;   // 8-bit wrap
                OP_DOUBLE: r[i*`NOC_LANEW +: `NOC_LANEW] = lane_t'(l * 2);
                default:   r[i*`NOC_LANEW +: `NOC_LANEW] = l;
            endcase
        end
        if (op == OP_SUM) r[`NOC_LANEW-1:0] = sum;
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_data(input string name, input flit_data_t got,
                              input flit_data_t exp, input int test);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors[test]++;
        end
    endtask

    task automatic check_dest(input string name, input node_id_t got,
                              input node_id_t exp, input int test);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors[test]++;
        end
    endtask

    task automatic check_op(input string name, input pe_op_e got,
                            input pe_op_e exp, input int test);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors[test]++;
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp, input int test);
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors[test]++;
        end
    endtask

    task automatic report_test(input int test);
        $display("Test %-10s %s (%0d errors)", test_name[test],
                 (errors[test] == 0) ? "ok" : "failed", errors[test]);
    endtask

    // ------------------------------------------------------------------------
    // Monitor and driver tasks of the main loop
    // ------------------------------------------------------------------------
    task automatic watch_outputs();
        tag_t t;
        t = m_ttag;
        if (held && !m_tvalid) begin
            $display("Error: m_tvalid fell at %0t before the host took the result", $time);
            errors[T_HOLD]++;
        end else if (held) begin
            check_data("m_tdata", m_tdata, hold_data, T_HOLD);
            check_dest("m_tdest", m_tdest, hold_dest, T_HOLD);
            check_op("m_top", m_top, hold_op, T_HOLD);
            check_tag("m_ttag", m_ttag, hold_tag, T_HOLD);
        end
        held      = m_tvalid && !m_tready;
        hold_data = m_tdata;
        hold_dest = m_tdest;
        hold_op   = m_top;
        hold_tag  = m_ttag;
        if (m_tvalid && m_tready) begin
            if (!pending[t]) begin
                $display("Error: result with tag %0d at %0t was not expected", t, $time);
                errors[T_DONE]++;
            end else begin
                check_dest("m_tdest", m_tdest, exp_dest[t], T_ROUTE);
                check_data("m_tdata", m_tdata, exp_data[t], T_DATA);
                check_op("m_top", m_top, exp_op[t], T_DATA);
                pending[t] = 1'b0;
                outstanding--;
            end
        end
    endtask

    task automatic record_input();
        exp_data[s_ttag] = model_result(s_tdata, s_top);
        exp_dest[s_ttag] = s_tdest;
        exp_op[s_ttag]   = s_top;
        if (s_tdest inside {[1:`NOC_NODES]}) begin
            pending[s_ttag] = 1'b1;   // Dropped flits never return
            outstanding++;
        end
        sent++;
    endtask

    task automatic drive_next();
        logic [31:0] r;
        r = next_rand();
        if (sent < NUM_FLITS && r[3:2] != 2'b00) begin
            s_tvalid = 1'b1;
            s_tdest  = node_id_t'(r[6:4]);
            s_top    = pe_op_e'(r[9:8]);
            s_ttag   = tag_t'(sent);
            s_tdata  = next_rand();
        end else begin
            s_tvalid = 1'b0;
        end
    endtask

    initial begin
        logic took;
        int   total;
        clk       = 1'b0;
        rst       = 1'b1;
        s_tvalid  = 1'b0;
        s_tdata   = '0;
        s_tdest   = '0;
        s_top     = OP_PASS;
        s_ttag    = '0;
        m_tready  = 1'b0;
        rng_state = 32'hb176_1e62;
        sent        = 0;
        outstanding = 0;
        cycles      = 0;
        timed_out   = 1'b0;
        held        = 1'b0;
        took        = 1'b0;
        total       = 0;
        for (int i = 0; i < 5; i++) errors[i] = 0;
        for (int i = 0; i < NUM_TAGS; i++) pending[i] = 1'b0;

        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        if (m_tvalid !== 1'b0) begin
            $display("** Error: m_tvalid = %h after reset, expected 0", m_tvalid);
            errors[T_RESET]++;
        end
        if (s_tready !== 1'b1) begin
            $display("** Error: s_tready = %h after reset, expected 1", s_tready);
            errors[T_RESET]++;
        end
        report_test(T_RESET);

        // Inputs change 2 ns after the edge and outputs are sampled at the falling edge
        while (!timed_out && (sent < NUM_FLITS || outstanding != 0)) begin
            @(posedge clk);
            #2;
            m_tready = (next_rand() & 32'h3) != 0;
            if (took || !s_tvalid) drive_next();
            @(negedge clk);
            took = s_tvalid && s_tready;
            watch_outputs();
            if (took) record_input();
            cycles++;
            if (cycles + RST_CYCLES >= MAX_CYCLES) timed_out = 1'b1;
        end

        if (timed_out) begin
            $display("Timeout after %0d cycles with %0d of %0d flits sent, %0d results missing",
                     cycles, sent, NUM_FLITS, outstanding);
            errors[T_DONE]++;
        end
        for (int i = 1; i < 5; i++) report_test(i);
        for (int i = 0; i < 5; i++) total += errors[i];
        $display("Summary: 5 tests, %0d flits sent, %0d errors", sent, total);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
verilog/noc_pkg.sv
verilog/pe_pkg.sv
verilog/lane_counter.sv
verilog/pe_lanes.sv
verilog/pe_ctrl.sv
verilog/hub_router.sv
verilog/noc_star_top.sv
bench/tb_noc_star.sv

// File: run_sim.sh
#!/bin/sh
# Build the NoC star testbench with Verilator, run it and scan the log
LOG=sim.log

rm -f "$LOG"
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_noc_star \
    -Mdir obj_dir -o tb_noc_star \
    && ./obj_dir/tb_noc_star > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG" && exit 1 || exit 0
